//--- adapter/amo_alu.sv
// combinational AMO datapath, new memory word from the old word and the request operand
`timescale 1ns/1ps

module amo_alu import tcdm_pkg::*; (
  input  amo_op_e              op_i,
  input  logic [DataWidth-1:0] mem_i,
  input  logic [DataWidth-1:0] operand_i,
  output logic [DataWidth-1:0] result_o
);

  logic               is_signed;
  logic [DataWidth:0] diff;
  logic               mem_lt;

  // ------------------------------------------------------------
  // shared compare for max/min
  // ------------------------------------------------------------
  assign is_signed = op_i inside {AmoMax, AmoMin};

  // extend by sign or zero, bit 32 of the difference is then mem < operand
  assign diff   = {is_signed & mem_i[DataWidth-1], mem_i} -
                  {is_signed & operand_i[DataWidth-1], operand_i};
  assign mem_lt = diff[DataWidth];

  // ------------------------------------------------------------
  // result select
  // ------------------------------------------------------------
  always_comb begin
    case (op_i)
      AmoSwap: begin
        result_o = operand_i;
      end
      AmoAdd: begin
        result_o = mem_i + operand_i;
      end
      AmoAnd: begin
        result_o = mem_i & operand_i;
      end
      AmoOr: begin
        result_o = mem_i | operand_i;
      end
      AmoXor: begin
        result_o = mem_i ^ operand_i;
      end
      AmoMax, AmoMaxu: begin
        result_o = mem_lt ? operand_i : mem_i;
      end
      AmoMin, AmoMinu: begin
        result_o = mem_lt ? mem_i : operand_i;
      end
      default: begin
        // no read-modify-write, word stays as it is
        result_o = mem_i;
      end
    endcase
  end

endmodule

//--- adapter/lrsc_monitor.sv
// LR/SC reservation tracker, watches every accepted request and flags a successful SC
`timescale 1ns/1ps

module lrsc_monitor import tcdm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      accept_i,
  input  tcdm_req_t req_i,
  output logic      sc_success_o
);

  lrsc_resv_t                           resv_q, resv_d;
  logic [UniqueCoreWidth-1:0]           core_id;
  logic [AddrWidth-ByteOffsetWidth-1:0] word_addr;
  logic                                 addr_hit;
  logic                                 breaks_resv;

  // ------------------------------------------------------------
  // core identity from the metadata
  // ------------------------------------------------------------
  always_comb begin
    if (!req_i.meta.ini_addr[IniAddrWidth-1]) begin
      // local tile, group of this bank taken as zero
      core_id = {{(IniAddrWidth-1){1'b0}}, req_i.meta.tile_id,
                 req_i.meta.ini_addr[IniAddrWidth-2:0]};
    end else begin
      // remote tile, low initiator bits carry the group
      core_id = {req_i.meta.ini_addr[IniAddrWidth-2:0], req_i.meta.tile_id,
                 req_i.meta.core_id};
    end
  end

  assign word_addr = req_i.addr[AddrWidth-1:ByteOffsetWidth];
  assign addr_hit  = (word_addr == resv_q.addr);

  // stores and read-modify-write AMOs modify the word
  assign breaks_resv = is_rmw_amo(req_i.amo) |
                       (req_i.write & ~(req_i.amo inside {AmoLr, AmoSc}));

  // ------------------------------------------------------------
  // reservation update
  // ------------------------------------------------------------
  always_comb begin
    resv_d       = resv_q;
    sc_success_o = 1'b0;
    if (accept_i) begin
      // new LR only replaces a reservation of the same core
      if (req_i.amo == AmoLr && (!resv_q.valid || resv_q.core == core_id)) begin
        resv_d.valid = 1'b1;
        resv_d.addr  = word_addr;
        resv_d.core  = core_id;
      end
      if (addr_hit && breaks_resv) begin
        resv_d.valid = 1'b0;
      end
      // any SC of the owner ends the reservation
      if (resv_q.valid && req_i.amo == AmoSc && resv_q.core == core_id) begin
        resv_d.valid = 1'b0;
        sc_success_o = addr_hit;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resv_q <= '0;
    end else begin
      resv_q <= resv_d;
    end
  end

endmodule

//--- adapter/tcdm_req_ctrl.sv
// request controller of the bank, turns accepted requests into SRAM accesses and AMO write-backs
`timescale 1ns/1ps

module tcdm_req_ctrl import tcdm_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // request stream
  input  logic                 in_valid_i,
  input  tcdm_req_t            in_req_i,
  output logic                 in_ready_o,
  // response buffer occupancy
  input  logic                 buf_full_i,
  // from the reservation monitor
  input  logic                 sc_success_i,
  // AMO ALU
  output amo_op_e              amo_op_o,
  output logic [DataWidth-1:0] amo_operand_o,
  input  logic [DataWidth-1:0] amo_result_i,
  // SRAM port
  output sram_req_t            sram_req_o,
  input  logic [DataWidth-1:0] sram_rdata_i,
  // response push
  output logic                 resp_push_o,
  output logic [DataWidth-1:0] resp_data_o,
  output tcdm_meta_t           resp_meta_o
);

  typedef enum logic {
    Idle,
    WriteBack
  } state_e;

  state_e                  state_q, state_d;
  logic                    accept;
  logic                    is_rmw;
  logic                    is_lr;
  logic                    is_sc;
  logic                    is_store;
  logic [WordIdxWidth-1:0] req_idx;

  // registered AMO operation
  amo_op_e                 amo_op_q;
  logic [DataWidth-1:0]    operand_q;
  logic [WordIdxWidth-1:0] idx_q;

  // response bookkeeping
  logic                    push_q;
  logic                    sc_q;
  logic                    sc_ok_q;
  tcdm_meta_t              meta_q;

  // ------------------------------------------------------------
  // request decode
  // ------------------------------------------------------------
  // stalled during AMO write-back and while a response is held
  assign in_ready_o = (state_q == Idle) & ~buf_full_i;
  assign accept     = in_valid_i & in_ready_o;

  assign is_rmw   = is_rmw_amo(in_req_i.amo);
  assign is_lr    = (in_req_i.amo == AmoLr);
  assign is_sc    = (in_req_i.amo == AmoSc);
  // plain store, the only access without a response
  assign is_store = in_req_i.write & ~(is_rmw | is_lr | is_sc);

  assign req_idx = in_req_i.addr[ByteOffsetWidth +: WordIdxWidth];

  // ------------------------------------------------------------
  // FSM and SRAM port
  // ------------------------------------------------------------
  always_comb begin
    state_d          = state_q;
    // default: pass the accepted request through
    sram_req_o.req   = accept;
    sram_req_o.write = accept & (is_store | (is_sc & sc_success_i));
    sram_req_o.idx   = req_idx;
    sram_req_o.wdata = in_req_i.wdata;
    sram_req_o.be    = in_req_i.be;

    case (state_q)
      Idle: begin
        if (accept && is_rmw) begin
          state_d = WriteBack;
        end
      end
      WriteBack: begin
        // claim the SRAM for the ALU result, full word
        sram_req_o.req   = 1'b1;
        sram_req_o.write = 1'b1;
        sram_req_o.idx   = idx_q;
        sram_req_o.wdata = amo_result_i;
        sram_req_o.be    = '1;
        state_d          = Idle;
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      push_q  <= 1'b0;
      sc_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      // loads, LR, AMOs and SC answer one cycle later
      push_q  <= accept & ~is_store;
      sc_q    <= accept & is_sc;
    end
  end

  // payload captured on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      meta_q  <= in_req_i.meta;
      sc_ok_q <= sc_success_i;
    end
    if (accept && is_rmw) begin
      amo_op_q  <= in_req_i.amo;
      operand_q <= in_req_i.wdata;
      idx_q     <= req_idx;
    end
  end

  // ------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------
  assign amo_op_o      = amo_op_q;
  assign amo_operand_o = operand_q;

  assign resp_push_o = push_q;
  assign resp_meta_o = meta_q;
  // SC returns 0 on success and 1 on failure, all else the SRAM word
  assign resp_data_o = sc_q ? {{(DataWidth-1){1'b0}}, ~sc_ok_q} : sram_rdata_i;

endmodule

//--- common/tcdm_pkg.sv
// shared sizes, AMO opcodes and bus structs for the TCDM bank, imported by every bank module
package tcdm_pkg;

  // ------------------------------------------------------------
  // cluster shape
  // ------------------------------------------------------------
  localparam int unsigned NumGroups        = 4;
  localparam int unsigned NumTilesPerGroup = 4;
  localparam int unsigned NumCoresPerTile  = 4;

  // ------------------------------------------------------------
  // bus and bank sizes
  // ------------------------------------------------------------
  localparam int unsigned AddrWidth       = 32;
  localparam int unsigned DataWidth       = 32;
  localparam int unsigned BeWidth         = DataWidth / 8;
  localparam int unsigned NumWords        = 256;
  localparam int unsigned WordIdxWidth    = $clog2(NumWords);
  // byte offset inside a word, dropped from the word index
  localparam int unsigned ByteOffsetWidth = $clog2(BeWidth);

  // initiator field, msb set means the request came from a remote tile
  localparam int unsigned IniAddrWidth    = $clog2(NumCoresPerTile + NumGroups);
  localparam int unsigned TileIdWidth     = $clog2(NumTilesPerGroup);
  localparam int unsigned CoreIdWidth     = $clog2(NumCoresPerTile);
  // group, tile and core packed into one cluster-wide identity
  localparam int unsigned UniqueCoreWidth =
    $clog2(NumGroups * NumTilesPerGroup * NumCoresPerTile);

  // opcodes 4'hC and 4'hD are not used and act as a plain access
  typedef enum logic [3:0] {
    AmoNone = 4'h0,
    AmoSwap = 4'h1,
    AmoAdd  = 4'h2,
    AmoAnd  = 4'h3,
    AmoOr   = 4'h4,
    AmoXor  = 4'h5,
    AmoMax  = 4'h6,
    AmoMaxu = 4'h7,
    AmoMin  = 4'h8,
    AmoMinu = 4'h9,
    AmoLr   = 4'hA,
    AmoSc   = 4'hB
  } amo_op_e;

  // requester identity, echoed back with each response
  typedef struct packed {
    logic [IniAddrWidth-1:0] ini_addr;
    logic [TileIdWidth-1:0]  tile_id;
    logic [CoreIdWidth-1:0]  core_id;
  } tcdm_meta_t;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    amo_op_e              amo;
    logic                 write;
    logic [DataWidth-1:0] wdata;
    logic [BeWidth-1:0]   be;
    tcdm_meta_t           meta;
  } tcdm_req_t;

  // single-cycle SRAM port
  typedef struct packed {
    logic                    req;
    logic                    write;
    logic [WordIdxWidth-1:0] idx;
    logic [DataWidth-1:0]    wdata;
    logic [BeWidth-1:0]      be;
  } sram_req_t;

  // one LR reservation, word granular
  typedef struct packed {
    logic                                 valid;
    logic [AddrWidth-ByteOffsetWidth-1:0] addr;
    logic [UniqueCoreWidth-1:0]           core;
  } lrsc_resv_t;

  // read-modify-write AMOs, everything from swap up to minu
  function automatic logic is_rmw_amo(amo_op_e op);
    return op inside {AmoSwap, AmoAdd, AmoAnd, AmoOr, AmoXor,
                      AmoMax, AmoMaxu, AmoMin, AmoMinu};
  endfunction

endpackage

//--- hdl/tcdm_bank.sv
// shared-memory bank top, instantiate once per bank and connect the valid/ready request stream
`timescale 1ns/1ps

module tcdm_bank import tcdm_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // request stream
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  tcdm_req_t            in_req_i,
  // response stream
  output logic                 in_valid_o,
  input  logic                 in_ready_i,
  output logic [DataWidth-1:0] in_rdata_o,
  output tcdm_meta_t           in_meta_o
);

  // ------------------------------------------------------------
  // internal nets
  // ------------------------------------------------------------
  logic                 accept;
  logic                 sc_success;
  amo_op_e              amo_op;
  logic [DataWidth-1:0] amo_operand;
  logic [DataWidth-1:0] amo_result;
  sram_req_t            sram_req;
  logic [DataWidth-1:0] sram_rdata;
  logic                 resp_push;
  logic [DataWidth-1:0] resp_data;
  tcdm_meta_t           resp_meta;
  logic                 buf_full;

  // handshake seen by the reservation monitor
  assign accept = in_valid_i & in_ready_o;

  tcdm_req_ctrl i_req_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .in_valid_i    (in_valid_i),
    .in_req_i      (in_req_i),
    .in_ready_o    (in_ready_o),
    .buf_full_i    (buf_full),
    .sc_success_i  (sc_success),
    .amo_op_o      (amo_op),
    .amo_operand_o (amo_operand),
    .amo_result_i  (amo_result),
    .sram_req_o    (sram_req),
    .sram_rdata_i  (sram_rdata),
    .resp_push_o   (resp_push),
    .resp_data_o   (resp_data),
    .resp_meta_o   (resp_meta)
  );

  lrsc_monitor i_lrsc_monitor (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .accept_i     (accept),
    .req_i        (in_req_i),
    .sc_success_o (sc_success)
  );

  // old word straight from the SRAM output register
  amo_alu i_amo_alu (
    .op_i      (amo_op),
    .mem_i     (sram_rdata),
    .operand_i (amo_operand),
    .result_o  (amo_result)
  );

  tcdm_sram i_sram (
    .clk_i   (clk_i),
    .req_i   (sram_req),
    .rdata_o (sram_rdata)
  );

  tcdm_resp_buffer i_resp_buffer (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (resp_push),
    .data_i  (resp_data),
    .meta_i  (resp_meta),
    .full_o  (buf_full),
    .valid_o (in_valid_o),
    .ready_i (in_ready_i),
    .rdata_o (in_rdata_o),
    .meta_o  (in_meta_o)
  );

endmodule

//--- hdl/tcdm_resp_buffer.sv
// one-entry fall-through response buffer, sits between the request controller and the requester
`timescale 1ns/1ps

module tcdm_resp_buffer import tcdm_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // from the request controller
  input  logic                 push_i,
  input  logic [DataWidth-1:0] data_i,
  input  tcdm_meta_t           meta_i,
  output logic                 full_o,
  // to the requester
  output logic                 valid_o,
  input  logic                 ready_i,
  output logic [DataWidth-1:0] rdata_o,
  output tcdm_meta_t           meta_o
);

  logic                 valid_q;
  logic [DataWidth-1:0] data_q;
  tcdm_meta_t           meta_q;
  logic                 pop;
  logic                 store;

  // ------------------------------------------------------------
  // output side
  // ------------------------------------------------------------
  // a fresh push is visible in the same cycle
  assign valid_o = valid_q | push_i;
  assign rdata_o = valid_q ? data_q : data_i;
  assign meta_o  = valid_q ? meta_q : meta_i;

  assign pop = valid_o & ready_i;

  // blocks new requests while a response sits here without being taken
  assign full_o = valid_o & ~ready_i;

  // push is kept unless it passes straight through to the requester
  assign store = push_i & ~(pop & ~valid_q);

  // ------------------------------------------------------------
  // entry state
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (store) begin
      valid_q <= 1'b1;
    end else if (pop) begin
      valid_q <= 1'b0;
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    if (store) begin
      data_q <= data_i;
      meta_q <= meta_i;
    end
  end

endmodule

//--- hdl/tcdm_sram.sv
// single-port word SRAM with byte-enable writes, read data shows up one cycle after the request
`timescale 1ns/1ps

module tcdm_sram import tcdm_pkg::*; (
  input  logic                 clk_i,
  input  sram_req_t            req_i,
  output logic [DataWidth-1:0] rdata_o
);

  // storage, contents are undefined after power-up
  logic [DataWidth-1:0] mem_q [NumWords];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.write) begin
        // only enabled bytes change
        for (int b = 0; b < BeWidth; b++) begin
          if (req_i.be[b]) begin
            mem_q[req_i.idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        // output register keeps its value on writes
        rdata_o <= mem_q[req_i.idx];
      end
    end
  end

endmodule

//--- list.f
+incdir+verification
common/tcdm_pkg.sv
adapter/amo_alu.sv
adapter/lrsc_monitor.sv
adapter/tcdm_req_ctrl.sv
hdl/tcdm_sram.sv
hdl/tcdm_resp_buffer.sv
hdl/tcdm_bank.sv
verification/tb_tcdm_bank.sv

//--- run.sh
#!/bin/sh
# builds the bank testbench with Verilator, runs it and looks for the pass line in the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_tcdm_bank -f list.f -o tb_tcdm_bank \
  || { echo "build failed"; exit 1; }

./obj_dir/tb_tcdm_bank > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log

grep -q "=== PASS ===" sim.log && echo "result: passed" || { echo "result: failed"; exit 1; }

//--- verification/tcdm_tb_checks.svh
// concurrent checks and the request, response and drain tasks that the bank testbench top includes
`ifndef TCDM_TB_CHECKS_SVH
`define TCDM_TB_CHECKS_SVH

  // ------------------------------------------------------------
  // protocol and timing assertions
  // ------------------------------------------------------------
  // held response stays put until taken
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_valid_o && !in_ready_i |=> in_valid_o && $stable(in_rdata_o) && $stable(in_meta_o))
    else report_failure("response dropped or changed while the requester stalled");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_valid_o && !in_ready_i |-> !in_ready_o)
    else report_failure($sformatf("CHECK FAILED in_ready_o got %h expected 0", in_ready_o));

  // one-cycle response latency
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_accept && gives_response(in_req_i) |=> in_valid_o)
    else report_failure($sformatf("CHECK FAILED in_valid_o got %h expected 1", in_valid_o));

  // write-back cycle after an AMO
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_accept && rmw_op(in_req_i.amo) |=> !in_ready_o)
    else report_failure($sformatf("CHECK FAILED in_ready_o got %h expected 0", in_ready_o));

  // quiet during reset and the cycle after
  assert property (@(posedge clk_i) !rst_ni |-> !in_valid_o)
    else report_failure($sformatf("CHECK FAILED in_valid_o got %h expected 0", in_valid_o));

  assert property (@(posedge clk_i) !rst_ni |=> !in_valid_o)
    else report_failure($sformatf("CHECK FAILED in_valid_o got %h expected 0", in_valid_o));

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  // ------------------------------------------------------------
  // request side
  // ------------------------------------------------------------
  task automatic send_req(input tcdm_req_t req);
    int unsigned waited;
    waited = 0;
    @(posedge clk_i);
    in_valid_i <= 1'b1;
    in_req_i   <= req;
    @(negedge clk_i);
    while (!in_ready_o) begin
      waited++;
      if (waited > ReqTimeout) begin
        report_failure("timeout while waiting for in_ready_o");
      end
      @(negedge clk_i);
    end
    // handshake completes on this edge
    @(posedge clk_i);
    in_valid_i <= 1'b0;
  endtask

  // ------------------------------------------------------------
  // response side with the requester model
  // ------------------------------------------------------------
  initial begin
    logic [31:0] exp_data;
    tcdm_meta_t  exp_meta;
    in_ready_i = 1'b0;
    resp_count = 0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && in_valid_o && in_ready_i) begin
        // every handshake counts even when nothing is owed
        resp_count++;
        if (exp_data_q.size() != 0) begin
          exp_data = exp_data_q.pop_front();
          exp_meta = exp_meta_q.pop_front();
          check_value("in_rdata_o", in_rdata_o, exp_data);
          check_value("in_meta_o", {25'd0, in_meta_o}, {25'd0, exp_meta});
        end
      end
      @(posedge clk_i);
      in_ready_i <= stall_en ? ($urandom_range(0, 1) == 1) : 1'b1;
    end
  end

  task automatic wait_drained();
    int unsigned waited;
    waited = 0;
    while (exp_data_q.size() != 0) begin
      waited++;
      if (waited > DrainTimeout) begin
        report_failure("timeout while waiting for outstanding responses");
      end
      @(negedge clk_i);
    end
  endtask

`endif

//--- verification/tb_tcdm_bank.sv
// bank testbench top that runs store/load, AMO, LR/SC and back-pressure sequences
`timescale 1ns/1ps

module tb_tcdm_bank import tcdm_pkg::*; ();

  localparam int unsigned ReqTimeout   = 200;
  localparam int unsigned DrainTimeout = 4000;
  // signed and unsigned extremes for max/min
  localparam logic [31:0] Corner [4] = '{32'h0000_0000, 32'h7fff_ffff,
                                         32'h8000_0000, 32'hffff_ffff};
  localparam amo_op_e RmwOps [9] = '{AmoSwap, AmoAdd, AmoAnd, AmoOr, AmoXor,
                                     AmoMax, AmoMaxu, AmoMin, AmoMinu};

  logic        clk_i;
  logic        rst_ni;
  logic        in_valid_i;
  logic        in_ready_o;
  tcdm_req_t   in_req_i;
  logic        in_valid_o;
  logic        in_ready_i;
  logic [31:0] in_rdata_o;
  tcdm_meta_t  in_meta_o;

  // random response stalls on/off
  logic        stall_en;
  logic        req_accept;

  // reference memory and reservation
  logic [31:0] ref_mem [NumWords];
  logic        resv_valid;
  logic [7:0]  resv_idx;
  int          resv_core;

  // responses still owed by the bank in request order
  logic [31:0] exp_data_q [$];
  tcdm_meta_t  exp_meta_q [$];
  int          exp_count;
  int          resp_count;

  assign req_accept = in_valid_i & in_ready_o;

  tcdm_bank DUT (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_req_i   (in_req_i),
    .in_valid_o (in_valid_o),
    .in_ready_i (in_ready_i),
    .in_rdata_o (in_rdata_o),
    .in_meta_o  (in_meta_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // failure and reference rules
  // ------------------------------------------------------------
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic logic rmw_op(amo_op_e op);
    return (op >= AmoSwap) && (op <= AmoMinu);
  endfunction

  // everything but a plain store gets an answer
  function automatic logic gives_response(tcdm_req_t r);
    return rmw_op(r.amo) || (r.amo == AmoLr) || (r.amo == AmoSc) || !r.write;
  endfunction

  // cluster-wide core number as group*16 + tile*4 + core
  function automatic int core_of(tcdm_meta_t m);
    if (m.ini_addr[2]) begin
      return int'(m.ini_addr[1:0]) * 16 + int'(m.tile_id) * 4 + int'(m.core_id);
    end
    // on the local tile the initiator bits name the core
    return int'(m.tile_id) * 4 + int'(m.ini_addr[1:0]);
  endfunction

  function automatic logic [31:0] amo_expect(amo_op_e op, logic [31:0] old,
                                             logic [31:0] opnd);
    case (op)
      AmoSwap: return opnd;
      AmoAdd:  return old + opnd;
      AmoAnd:  return old & opnd;
      AmoOr:   return old | opnd;
      AmoXor:  return old ^ opnd;
      AmoMax:  return ($signed(old) > $signed(opnd)) ? old : opnd;
      AmoMaxu: return (old > opnd) ? old : opnd;
      AmoMin:  return ($signed(old) < $signed(opnd)) ? old : opnd;
      AmoMinu: return (old < opnd) ? old : opnd;
      default: return old;
    endcase
  endfunction

  function automatic void write_ref(logic [7:0] idx, logic [31:0] data, logic [3:0] be);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        ref_mem[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
  endfunction

  function automatic void expect_resp(logic [31:0] data, tcdm_meta_t meta);
    exp_data_q.push_back(data);
    exp_meta_q.push_back(meta);
    exp_count++;
  endfunction

  function automatic tcdm_meta_t random_meta();
    logic [31:0] r;
    r = $urandom;
    return tcdm_meta_t'(r[6:0]);
  endfunction

  `include "tcdm_tb_checks.svh"

  // model the request and then hand it to the bus
  task automatic issue_op(input amo_op_e op, input logic wr, input logic [7:0] idx,
                          input logic [31:0] data, input logic [3:0] be,
                          input tcdm_meta_t meta);
    tcdm_req_t   req;
    logic [31:0] old;
    int          core;
    old  = ref_mem[idx];
    core = core_of(meta);
    req  = '{addr: {22'd0, idx, 2'b00}, amo: op, write: wr, wdata: data, be: be, meta: meta};
    if (op == AmoLr) begin
      if (!resv_valid || resv_core == core) begin
        resv_valid = 1'b1;
        resv_idx   = idx;
        resv_core  = core;
      end
      expect_resp(old, meta);
    end else if (op == AmoSc) begin
      if (resv_valid && resv_core == core && resv_idx == idx) begin
        write_ref(idx, data, be);
        expect_resp(32'd0, meta);
      end else begin
        expect_resp(32'd1, meta);
      end
      // owner loses the reservation on any SC
      if (resv_valid && resv_core == core) begin
        resv_valid = 1'b0;
      end
    end else if (rmw_op(op)) begin
      ref_mem[idx] = amo_expect(op, old, data);
      if (resv_idx == idx) begin
        resv_valid = 1'b0;
      end
      expect_resp(old, meta);
    end else if (wr) begin
      write_ref(idx, data, be);
      if (resv_idx == idx) begin
        resv_valid = 1'b0;
      end
    end else begin
      expect_resp(old, meta);
    end
    send_req(req);
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial begin
    tcdm_meta_t  meta_a;
    tcdm_meta_t  meta_b;
    tcdm_meta_t  meta;
    logic [7:0]  idx;
    logic [31:0] data;
    logic [31:0] opnd;
    int unsigned sel;
    int unsigned seed_ret;
    seed_ret   = $urandom(64828);
    rst_ni     = 1'b0;
    in_valid_i = 1'b0;
    in_req_i   = '0;
    stall_en   = 1'b0;
    resv_valid = 1'b0;
    resv_idx   = 8'd0;
    resv_core  = 0;
    exp_count  = 0;
    // local core 9 and remote core 39
    meta_a = '{ini_addr: 3'b001, tile_id: 2'd2, core_id: 2'd0};
    meta_b = '{ini_addr: 3'b110, tile_id: 2'd1, core_id: 2'd3};
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    // known contents for every word
    for (int i = 0; i < NumWords; i++) begin
      issue_op(AmoNone, 1'b1, 8'(i), $urandom, 4'hf, random_meta());
    end

    // partial stores read back
    for (int n = 0; n < 24; n++) begin
      idx = 8'($urandom);
      issue_op(AmoNone, 1'b1, idx, $urandom, 4'($urandom), random_meta());
      issue_op(AmoNone, 1'b0, idx, 32'd0, 4'h0, random_meta());
    end
    wait_drained();

    // every AMO on corner pairs and one random pair
    for (int o = 0; o < 9; o++) begin
      for (int k = 0; k < 5; k++) begin
        idx  = 8'($urandom);
        data = (k < 4) ? Corner[k] : $urandom;
        opnd = (k < 4) ? Corner[(k + 1) % 4] : $urandom;
        issue_op(AmoNone, 1'b1, idx, data, 4'hf, random_meta());
        issue_op(RmwOps[o], 1'b1, idx, opnd, 4'hf, random_meta());
        issue_op(AmoNone, 1'b0, idx, 32'd0, 4'h0, random_meta());
      end
    end
    wait_drained();

    // LR/SC pairs, foreign SC, second SC, store in between, LR blocked
    issue_op(AmoLr, 1'b0, 8'd10, 32'd0, 4'h0, meta_a);
    issue_op(AmoSc, 1'b1, 8'd10, $urandom, 4'hf, meta_a);
    issue_op(AmoLr, 1'b0, 8'd11, 32'd0, 4'h0, meta_a);
    issue_op(AmoSc, 1'b1, 8'd11, $urandom, 4'hf, meta_b);
    issue_op(AmoSc, 1'b1, 8'd11, $urandom, 4'hf, meta_a);
    issue_op(AmoSc, 1'b1, 8'd11, $urandom, 4'hf, meta_a);
    issue_op(AmoLr, 1'b0, 8'd12, 32'd0, 4'h0, meta_a);
    issue_op(AmoNone, 1'b1, 8'd12, $urandom, 4'hf, meta_b);
    issue_op(AmoSc, 1'b1, 8'd12, $urandom, 4'hf, meta_a);
    issue_op(AmoLr, 1'b0, 8'd13, 32'd0, 4'h0, meta_a);
    issue_op(AmoLr, 1'b0, 8'd14, 32'd0, 4'h0, meta_b);
    issue_op(AmoSc, 1'b1, 8'd14, $urandom, 4'hf, meta_b);
    issue_op(AmoSc, 1'b1, 8'd13, $urandom, 4'hf, meta_a);
    for (int i = 10; i < 15; i++) begin
      issue_op(AmoNone, 1'b0, 8'(i), 32'd0, 4'h0, meta_b);
    end
    wait_drained();

    // random traffic on a few words under response stalls
    stall_en = 1'b1;
    for (int n = 0; n < 120; n++) begin
      idx  = 8'($urandom_range(0, 7));
      meta = ($urandom_range(0, 1) == 1) ? meta_a : meta_b;
      sel  = $urandom_range(0, 4);
      case (sel)
        1: issue_op(AmoNone, 1'b1, idx, $urandom, 4'($urandom), meta);
        2: issue_op(RmwOps[$urandom_range(0, 8)], 1'b1, idx, $urandom, 4'hf, meta);
        3: issue_op(AmoLr, 1'b0, idx, 32'd0, 4'h0, meta);
        4: issue_op(AmoSc, 1'b1, idx, $urandom, 4'($urandom), meta);
        default: issue_op(AmoNone, 1'b0, idx, 32'd0, 4'h0, meta);
      endcase
    end
    wait_drained();
    stall_en = 1'b0;

    // quiet window with the requester ready so a late extra response is counted
    repeat (8) @(negedge clk_i);
    check_value("response count", resp_count, exp_count);
    $display("=== PASS ===");
    $finish;
  end

endmodule
